// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_xosera_spi
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard verilog/*.sv) $(wildcard dv/*.sv)

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

check:
	@grep -q "All tests passed!" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/spi_cases.txt ====
# op reg bytesel value, all hex; W write value, R read and expect value, X reset
# lower case w and r run the frame at the minimum SCK half period
R 0 0 00
W 1 0 a5
R 1 0 a5
W 2 0 12
W 2 1 34
R 2 0 12
R 2 1 34
W 2 1 cd
R 2 0 12
R 2 1 cd
W 0 1 f0
W 1 1 e1
W 2 1 d2
W 3 1 c3
W 4 1 b4
W 5 1 a5
W 6 1 96
W 7 1 87
W 8 1 78
W 9 1 69
W a 1 5a
W b 1 4b
W c 1 3c
W d 1 2d
W e 1 1e
W f 1 0f
R 0 1 f0
R 1 1 e1
R 2 1 d2
R 3 1 c3
R 4 1 b4
R 5 1 a5
R 6 1 96
R 7 1 87
R 8 1 78
R 9 1 69
R a 1 5a
R b 1 4b
R c 1 3c
R d 1 2d
R e 1 1e
R f 1 0f
R 2 0 12
R 1 0 a5
w 5 0 11
w 5 0 22
w 5 0 33
r 5 0 33
r 5 1 a5
w 6 0 44
X 0 0 00
R 2 0 00
R 2 1 00
R 5 0 00
R f 1 00
R 0 0 00

// ==== dv/tb_xosera_spi.sv ====
`timescale 1ns/10ps

module tb_xosera_spi;

    localparam int PCLK_HALF    = 10;           // 20 ns period
    localparam int RST_CYCLES   = 8;
    localparam int DRIVE_DLY    = 2;            // inputs change after the edge
    localparam int SCK_HALF_MIN = 4;            // pclk cycles per SCK phase
    localparam int GAP_CYCLES   = 8;            // cs_n high between frames

    typedef struct packed {
        logic [7:0] op;                         // W R X, lower case w r at min SCK
        logic [3:0] reg_num;
        logic       bytesel;                    // 0 high byte, 1 low byte
        logic [7:0] value;                      // write data or expected read byte
    } spi_case_t;

    logic       pclk;
    logic       rst_i;
    logic       spi_sck;
    logic       spi_copi;
    logic       spi_cs_n;
    logic       spi_cipo;
    spi_case_t  cases [$];
    int         cycle_cnt = 0;
    int         limit     = 0;                  // armed once the cases are loaded
    int         pass_cnt  = 0;
    int         fail_cnt  = 0;
    logic [7:0] exp_first;                      // next first CIPO byte, FF until a read

    xosera_spi_top dut0 (
        .pclk       (pclk),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck),
        .spi_copi_i (spi_copi),
        .spi_cs_n_i (spi_cs_n),
        .spi_cipo_o (spi_cipo)
    );

    initial begin
        pclk = 1'b0;
        forever #PCLK_HALF pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge pclk);
        #DRIVE_DLY;                             // land just after the edge
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        wait_cycles(RST_CYCLES);
        rst_i = 1'b0;
        wait_cycles(2);
    endtask

    // mode 0, MSB first; CIPO is sampled just before each rising SCK
    task automatic shift_byte(input logic [7:0] tx, input int half, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_copi = tx[i];
            wait_cycles(half);
            rx[i]   = spi_cipo;
            spi_sck = 1'b1;
            wait_cycles(half);
            spi_sck = 1'b0;
        end
    endtask

    task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] data, input bit fast,
                             output logic [7:0] rx0, output logic [7:0] rx1);
        int half;
        half = fast ? SCK_HALF_MIN : SCK_HALF_MIN + int'($urandom % 4);
        spi_cs_n = 1'b0;
        wait_cycles(2);                         // target loads its first tx byte
        shift_byte(cmd, half, rx0);
        shift_byte(data, half, rx1);
        wait_cycles(half);
        spi_cs_n = 1'b1;
        wait_cycles(GAP_CYCLES);
    endtask

    task automatic compare_byte(input string what, input logic [7:0] got,
                                input logic [7:0] exp, inout int errs);
        if (got !== exp) begin
            $display("FAILED @%0t: %s is %02h, expected %02h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic load_cases(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] r;
        logic [31:0] b;
        logic [31:0] v;
        spi_case_t   c;
        ok = 1'b0;
        fd = $fopen("dv/spi_cases.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            n = $sscanf(line, "%c %h %h %h", op, r, b, v);
            // comment and blank lines fall out here
            if (n == 4 && (op == "W" || op == "R" || op == "X" || op == "w" || op == "r")) begin
                c.op      = op;
                c.reg_num = r[3:0];
                c.bytesel = b[0];
                c.value   = v[7:0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
        ok = (cases.size() > 0);
    endtask

    task automatic run_case(input int idx, input spi_case_t c);
        logic [7:0] cmd;
        logic [7:0] rx0;
        logic [7:0] rx1;
        int         errs;
        bit         fast;
        bit         is_wr;
        errs  = 0;
        fast  = (c.op == "w") || (c.op == "r");
        is_wr = (c.op == "W") || (c.op == "w");
        if (c.op == "X") begin
            apply_reset();
            exp_first = 8'hFF;                  // response register back to its reset value
        end else begin
            cmd = {is_wr, 2'b00, c.bytesel, c.reg_num};     // wr . . bs reg
            spi_frame(cmd, is_wr ? c.value : 8'h00, fast, rx0, rx1);
            compare_byte($sformatf("case %0d first CIPO byte", idx), rx0, exp_first, errs);
            compare_byte($sformatf("case %0d second CIPO byte", idx), rx1, 8'hFF, errs);
            if (!is_wr) begin
                exp_first = c.value;            // shows up in the next frame
            end
        end
        $display("case %0d: %c reg %0d bytesel %0d value %02h %s", idx, c.op, c.reg_num,
                 c.bytesel, c.value, (errs == 0) ? "pass" : "fail");
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    // one more read frame so the last read's byte gets shifted out
    task automatic flush_frame();
        logic [7:0] rx0;
        logic [7:0] rx1;
        int         errs;
        errs = 0;
        spi_frame(8'h00, 8'h00, 1'b0, rx0, rx1);
        compare_byte("final frame first CIPO byte", rx0, exp_first, errs);
        compare_byte("final frame second CIPO byte", rx1, 8'hFF, errs);
        $display("final frame: %s", (errs == 0) ? "pass" : "fail");
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    initial begin : watchdog
        wait (limit > 0);
        wait (cycle_cnt >= limit);
        $display("timeout: run did not finish within %0d clock cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        bit ok;
        void'($urandom(32'h97a3_7e3f));
        rst_i     = 1'b1;
        spi_sck   = 1'b0;                       // mode 0 idle
        spi_copi  = 1'b0;
        spi_cs_n  = 1'b1;
        exp_first = 8'hFF;
        load_cases(ok);
        if (!ok) begin
            $display("case file dv/spi_cases.txt is missing, unreadable or empty");
            $display("Test failures found");
            $finish;
        end else begin
            limit = cases.size() * 2 * 16 * 14 + 200;   // two frames per case at max SCK
            apply_reset();
            foreach (cases[i]) begin
                run_case(i, cases[i]);
            end
            flush_frame();
            $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

// ==== dv/xosera_spi_assert.sv ====
`timescale 1ns/10ps

module xosera_spi_assert #(
    parameter int N_CH = 1                      // number of valid/ready pairs watched
) (
    input logic            pclk,
    input logic            rst_i,
    input logic [N_CH-1:0] valid_i,             // one bit per channel
    input logic [N_CH-1:0] ready_i,
    input logic            excl_a_i,            // never high together with excl_b_i
    input logic            excl_b_i,
    input logic            offer_i,             // request offered to a buffer
    input logic            full_i               // that buffer is full
);

    // a valid may only drop after its handshake
    for (genvar i = 0; i < N_CH; i++) begin : g_hold
        hold_valid: assert property (@(posedge pclk) disable iff (rst_i)
            valid_i[i] && !ready_i[i] |=> valid_i[i])
            else $error("channel %0d valid dropped before ready", i);
    end

    one_addr_channel: assert property (@(posedge pclk) disable iff (rst_i)
        !(excl_a_i && excl_b_i))
        else $error("write and read address valid high together");

    no_offer_full: assert property (@(posedge pclk) disable iff (rst_i)
        !(offer_i && full_i))
        else $error("request offered while FIFO full");

endmodule

// AW, W, AR from the master, B and R back from the register bank
bind axil_bus_master xosera_spi_assert #(
    .N_CH (5)
) master_chk (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .valid_i  ({rvalid_i, bvalid_i, arvalid_o, wvalid_o, awvalid_o}),
    .ready_i  ({rready_o, bready_o, arready_i, wready_i, awready_i}),
    .excl_a_i (awvalid_o),
    .excl_b_i (arvalid_o),
    .offer_i  (1'b0),
    .full_i   (1'b0)
);

// push side and pop side of the request FIFO
bind bus_req_fifo xosera_spi_assert #(
    .N_CH (2)
) fifo_chk (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .valid_i  ({out_valid_o, in_valid_i}),
    .ready_i  ({out_ready_i, in_ready_o}),
    .excl_a_i (1'b0),
    .excl_b_i (1'b0),
    .offer_i  (in_valid_i),
    .full_i   (!in_ready_o)
);

// ==== tb.f ====
verilog/xosera_pkg.sv
verilog/spi_target.sv
verilog/spi_bus_bridge.sv
verilog/bus_req_fifo.sv
verilog/axil_bus_master.sv
verilog/xosera_regs.sv
verilog/xosera_spi_top.sv
dv/xosera_spi_assert.sv
dv/tb_xosera_spi.sv

// ==== verilog/axil_bus_master.sv ====
`timescale 1ns/10ps

module axil_bus_master (
    input  logic                 pclk,
    input  logic                 rst_i,
    input  xosera_pkg::bus_req_t req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,   // only when idle
    output xosera_pkg::axil_aw_t aw_o,
    output logic                 awvalid_o,
    input  logic                 awready_i,
    output xosera_pkg::axil_w_t  w_o,
    output logic                 wvalid_o,
    input  logic                 wready_i,
    input  xosera_pkg::axil_b_t  b_i,
    input  logic                 bvalid_i,
    output logic                 bready_o,
    output xosera_pkg::axil_ar_t ar_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  xosera_pkg::axil_r_t  r_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    output logic                 rd_valid_o,    // one cycle at end of a read
    output logic [7:0]           rd_byte_o
);

    typedef enum logic [2:0] {ST_IDLE, ST_WADDR, ST_WRESP, ST_RADDR, ST_RDATA} state_t;

    state_t state;
    logic   bytesel_q;                          // lane for read data
    logic   aw_done;
    logic   w_done;

    assign req_ready_o = (state == ST_IDLE);
    assign bready_o    = (state == ST_WRESP);   // held high while waiting
    assign rready_o    = (state == ST_RDATA);
    assign aw_done     = !awvalid_o || awready_i;
    assign w_done      = !wvalid_o || wready_i;

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            state      <= ST_IDLE;
            awvalid_o  <= 1'b0;
            wvalid_o   <= 1'b0;
            arvalid_o  <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid_i && req_i.wr) begin
                        awvalid_o <= 1'b1;      // AW and W go out together
                        wvalid_o  <= 1'b1;
                        state     <= ST_WADDR;
                    end else if (req_valid_i) begin
                        arvalid_o <= 1'b1;
                        state     <= ST_RADDR;
                    end
                end
                ST_WADDR: begin
                    if (awready_i) begin
                        awvalid_o <= 1'b0;
                    end
                    if (wready_i) begin
                        wvalid_o <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (bvalid_i && b_i.resp == xosera_pkg::AXIL_RESP_OKAY) begin
                        state <= ST_IDLE;
                    end else if (bvalid_i) begin
                        awvalid_o <= 1'b1;      // error, reissue same write
                        wvalid_o  <= 1'b1;
                        state     <= ST_WADDR;
                    end
                end
                ST_RADDR: begin
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        state     <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (rvalid_i) begin
                        rd_valid_o <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == ST_IDLE && req_valid_i) begin
            aw_o.addr <= {req_i.reg_num, 1'b0};     // word index to byte address
            ar_o.addr <= {req_i.reg_num, 1'b0};
            w_o.data  <= {req_i.data, req_i.data};  // byte on both lanes
            w_o.strb  <= req_i.bytesel ? 2'b01 : 2'b10;
            bytesel_q <= req_i.bytesel;
        end
        if (state == ST_RDATA && rvalid_i) begin
            if (r_i.resp != xosera_pkg::AXIL_RESP_OKAY) begin
                rd_byte_o <= 8'hFF;             // failed read looks like no data
            end else begin
                rd_byte_o <= bytesel_q ? r_i.data[7:0] : r_i.data[15:8];
            end
        end
    end

endmodule

// ==== verilog/bus_req_fifo.sv ====
`timescale 1ns/10ps

module bus_req_fifo #(
    parameter int FIFO_DEPTH = 4                // power of two, 2 or more
) (
    input  logic                 pclk,
    input  logic                 rst_i,
    input  xosera_pkg::bus_req_t in_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,    // low when full
    output xosera_pkg::bus_req_t out_o,
    output logic                 out_valid_o,   // high when not empty
    input  logic                 out_ready_i
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    xosera_pkg::bus_req_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;               // wraps at FIFO_DEPTH
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;                // occupancy, 0..FIFO_DEPTH
    logic                 push;
    logic                 pop;

    assign in_ready_o  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out_valid_o = (count != '0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign out_o       = mem[rd_ptr];           // head of queue

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none, or both at once
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr] <= in_i;
        end
    end

endmodule

// ==== verilog/spi_bus_bridge.sv ====
`timescale 1ns/10ps

module spi_bus_bridge (
    input  logic                 pclk,
    input  logic                 rst_i,
    input  logic                 select_i,      // frame in progress
    input  logic                 rx_strobe_i,   // rx_byte_i valid
    input  logic [7:0]           rx_byte_i,
    input  logic                 tx_strobe_i,   // target latches tx_byte_o now
    output logic [7:0]           tx_byte_o,
    input  logic                 rd_valid_i,    // read data back from master
    input  logic [7:0]           rd_byte_i,
    output xosera_pkg::bus_req_t req_o,
    output logic                 req_valid_o,
    input  logic                 req_ready_i    // low when FIFO full
);

    xosera_pkg::spi_byte_u rx_u;                // received byte, two views
    xosera_pkg::spi_cmd_t  cmd_q;               // command byte of this frame
    logic                  second_q;            // next rx byte is the data byte
    logic                  tx_started;          // first tx byte already latched
    logic [7:0]            resp_q;              // byte from last read
    logic                  frame_done;
    logic                  load;

    assign rx_u       = rx_byte_i;
    assign frame_done = select_i && rx_strobe_i && second_q;
    assign load       = frame_done && !req_valid_o && req_ready_i;  // else frame dropped
    assign tx_byte_o  = tx_started ? 8'hFF : resp_q;   // read byte first, then FF

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            second_q    <= 1'b0;
            tx_started  <= 1'b0;
            req_valid_o <= 1'b0;
            resp_q      <= 8'hFF;               // no read yet
        end else begin
            if (!select_i) begin
                second_q   <= 1'b0;
                tx_started <= 1'b0;
            end else begin
                if (rx_strobe_i) begin
                    second_q <= ~second_q;
                end
                if (tx_strobe_i) begin
                    tx_started <= 1'b1;
                end
            end
            if (rd_valid_i) begin
                resp_q <= rd_byte_i;
            end
            if (load) begin
                req_valid_o <= 1'b1;            // offered the cycle after rx_strobe
            end else if (req_ready_i) begin
                req_valid_o <= 1'b0;            // transferred or idle
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (select_i && rx_strobe_i && !second_q) begin
            cmd_q <= rx_u.cmd;
        end
        if (load) begin
            req_o <= '{wr:      cmd_q.wr,
                       bytesel: cmd_q.bytesel,
                       reg_num: cmd_q.reg_num,
                       data:    rx_u.raw};
        end
    end

endmodule

// ==== verilog/spi_target.sv ====
`timescale 1ns/10ps

module spi_target (
    input  logic       pclk,
    input  logic       rst_i,
    input  logic       spi_sck_i,               // host clock, idles low (mode 0)
    input  logic       spi_copi_i,              // host data in
    input  logic       spi_cs_n_i,              // host select, active low
    output logic       spi_cipo_o,              // data back to host
    output logic       select_o,                // cs_n synced and inverted
    output logic       rx_strobe_o,             // one cycle, rx_byte_o valid
    output logic [7:0] rx_byte_o,               // last full byte received
    output logic       tx_strobe_o,             // new byte begins, tx_byte_i latched now
    input  logic [7:0] tx_byte_i                // byte to shift out next
);

    logic [1:0] sck_sync;                       // two-flop synchronisers
    logic [1:0] copi_sync;
    logic [1:0] cs_n_sync;
    logic       sck_prev;                       // for edge detect
    logic       sel_prev;                       // for select start detect
    logic       sck_rise;
    logic       sck_fall;
    logic       byte_done;                      // eighth rising edge of a byte
    logic [2:0] bit_cnt;                        // rising edges seen in this byte
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    assign select_o   = ~cs_n_sync[1];
    assign sck_rise   = sck_sync[1] & ~sck_prev;
    assign sck_fall   = ~sck_sync[1] & sck_prev;
    assign byte_done  = sck_rise && (bit_cnt == 3'd7);
    assign spi_cipo_o = tx_shift[7];           // MSB first

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            sck_sync  <= 2'b00;
            copi_sync <= 2'b00;
            cs_n_sync <= 2'b11;                 // deselected
            sck_prev  <= 1'b0;
            sel_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            copi_sync <= {copi_sync[0], spi_copi_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            sck_prev  <= sck_sync[1];
            sel_prev  <= select_o;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst_i || !select_o) begin           // idle whenever cs_n is high
            bit_cnt     <= 3'd0;
            rx_shift    <= 8'h00;
            tx_shift    <= 8'hFF;
            rx_strobe_o <= 1'b0;
            tx_strobe_o <= 1'b0;
        end else begin
            rx_strobe_o <= byte_done;
            tx_strobe_o <= !sel_prev || byte_done;  // frame start or byte boundary
            if (sck_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;     // wraps after 8 bits
                rx_shift <= {rx_shift[6:0], copi_sync[1]};
            end
            // the first falling edge of a byte keeps the freshly loaded MSB
            if (tx_strobe_o) begin
                tx_shift <= tx_byte_i;
            end else if (sck_fall && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b1};
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (byte_done) begin
            rx_byte_o <= {rx_shift[6:0], copi_sync[1]};   // include eighth bit
        end
    end

endmodule

// ==== verilog/xosera_pkg.sv ====
package xosera_pkg;

    localparam int REG_NUM_W   = 4;                 // 16 registers
    localparam int REG_DATA_W  = 16;                // register word width
    localparam int AXIL_ADDR_W = 5;                 // byte address, reg_num << 1

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // first byte of a frame: W . . BS R3 R2 R1 R0
    typedef struct packed {
        logic                 wr;                   // 1 = write, 0 = read
        logic [1:0]           rsvd;                 // ignored
        logic                 bytesel;              // 0 = high (even) byte, 1 = low (odd)
        logic [REG_NUM_W-1:0] reg_num;              // register index
    } spi_cmd_t;

    // same received byte seen as data or as command
    typedef union packed {
        logic [7:0] raw;                            // data byte view
        spi_cmd_t   cmd;                            // command byte view
    } spi_byte_u;

    typedef struct packed {
        logic                 wr;                   // write request
        logic                 bytesel;              // byte lane select
        logic [REG_NUM_W-1:0] reg_num;              // target register
        logic [7:0]           data;                 // write byte, don't care on reads
    } bus_req_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [REG_DATA_W-1:0]   data;
        logic [REG_DATA_W/8-1:0] strb;              // strb[1] = high byte
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [REG_DATA_W-1:0] data;
        logic [1:0]            resp;
    } axil_r_t;

endpackage

// ==== verilog/xosera_regs.sv ====
`timescale 1ns/10ps

module xosera_regs (
    input  logic                 pclk,
    input  logic                 rst_i,
    input  xosera_pkg::axil_aw_t aw_i,
    input  logic                 awvalid_i,
    output logic                 awready_o,
    input  xosera_pkg::axil_w_t  w_i,
    input  logic                 wvalid_i,
    output logic                 wready_o,
    output xosera_pkg::axil_b_t  b_o,
    output logic                 bvalid_o,
    input  logic                 bready_i,
    input  xosera_pkg::axil_ar_t ar_i,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    output xosera_pkg::axil_r_t  r_o,
    output logic                 rvalid_o,
    input  logic                 rready_i
);

    localparam int NUM_REGS = 2**xosera_pkg::REG_NUM_W;

    logic [xosera_pkg::REG_DATA_W-1:0] regs [NUM_REGS];
    logic [xosera_pkg::REG_DATA_W-1:0] rdata_q;     // captured read word
    logic [xosera_pkg::REG_NUM_W-1:0]  wr_idx;
    logic [xosera_pkg::REG_NUM_W-1:0]  rd_idx;
    logic                              wr_en;
    logic                              rd_en;

    assign wr_en     = awvalid_i && wvalid_i && !bvalid_o;  // AW and W taken together
    assign awready_o = wr_en;
    assign wready_o  = wr_en;
    assign arready_o = !rvalid_o;               // one read in flight
    assign rd_en     = arvalid_i && arready_o;
    assign wr_idx    = aw_i.addr[xosera_pkg::AXIL_ADDR_W-1:1];  // bit 0 is byte lane
    assign rd_idx    = ar_i.addr[xosera_pkg::AXIL_ADDR_W-1:1];
    assign b_o.resp  = xosera_pkg::AXIL_RESP_OKAY;
    assign r_o.data  = rdata_q;                 // full word, master picks the byte
    assign r_o.resp  = xosera_pkg::AXIL_RESP_OKAY;

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            if (w_i.strb[1]) begin
                regs[wr_idx][15:8] <= w_i.data[15:8];   // even byte
            end
            if (w_i.strb[0]) begin
                regs[wr_idx][7:0] <= w_i.data[7:0];     // odd byte
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_en) begin
                bvalid_o <= 1'b1;               // B one cycle after accept
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_en) begin
                rvalid_o <= 1'b1;               // R one cycle after AR
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (rd_en) begin
            rdata_q <= regs[rd_idx];
        end
    end

endmodule

// ==== verilog/xosera_spi_top.sv ====
`timescale 1ns/10ps

module xosera_spi_top #(
    parameter int FIFO_DEPTH = 4                // request buffer depth
) (
    input  logic pclk,
    input  logic rst_i,
    input  logic spi_sck_i,
    input  logic spi_copi_i,
    input  logic spi_cs_n_i,
    output logic spi_cipo_o
);

    logic                 select;               // spi target to bridge
    logic                 rx_strobe;
    logic [7:0]           rx_byte;
    logic                 tx_strobe;
    logic [7:0]           tx_byte;
    logic                 rd_valid;             // master to bridge
    logic [7:0]           rd_byte;
    xosera_pkg::bus_req_t req;                  // bridge to FIFO
    logic                 req_valid;
    logic                 req_ready;
    xosera_pkg::bus_req_t fifo_out;             // FIFO to master
    logic                 fifo_valid;
    logic                 fifo_ready;
    xosera_pkg::axil_aw_t aw;                   // AXI4-Lite link
    logic                 awvalid;
    logic                 awready;
    xosera_pkg::axil_w_t  w;
    logic                 wvalid;
    logic                 wready;
    xosera_pkg::axil_b_t  b;
    logic                 bvalid;
    logic                 bready;
    xosera_pkg::axil_ar_t ar;
    logic                 arvalid;
    logic                 arready;
    xosera_pkg::axil_r_t  r;
    logic                 rvalid;
    logic                 rready;

    spi_target spi_target0 (
        .pclk        (pclk),
        .rst_i       (rst_i),
        .spi_sck_i   (spi_sck_i),
        .spi_copi_i  (spi_copi_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_cipo_o  (spi_cipo_o),
        .select_o    (select),
        .rx_strobe_o (rx_strobe),
        .rx_byte_o   (rx_byte),
        .tx_strobe_o (tx_strobe),
        .tx_byte_i   (tx_byte)
    );

    spi_bus_bridge bridge0 (
        .pclk        (pclk),
        .rst_i       (rst_i),
        .select_i    (select),
        .rx_strobe_i (rx_strobe),
        .rx_byte_i   (rx_byte),
        .tx_strobe_i (tx_strobe),
        .tx_byte_o   (tx_byte),
        .rd_valid_i  (rd_valid),
        .rd_byte_i   (rd_byte),
        .req_o       (req),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready)
    );

    bus_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .pclk        (pclk),
        .rst_i       (rst_i),
        .in_i        (req),
        .in_valid_i  (req_valid),
        .in_ready_o  (req_ready),
        .out_o       (fifo_out),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready)
    );

    axil_bus_master master0 (
        .pclk        (pclk),
        .rst_i       (rst_i),
        .req_i       (fifo_out),
        .req_valid_i (fifo_valid),
        .req_ready_o (fifo_ready),
        .aw_o        (aw),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .w_o         (w),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .b_i         (b),
        .bvalid_i    (bvalid),
        .bready_o    (bready),
        .ar_o        (ar),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .r_i         (r),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .rd_valid_o  (rd_valid),
        .rd_byte_o   (rd_byte)
    );

    xosera_regs regs0 (
        .pclk      (pclk),
        .rst_i     (rst_i),
        .aw_i      (aw),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .w_i       (w),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .b_o       (b),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .ar_i      (ar),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .r_o       (r),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule
